/* Bender.yml */
package:
  name: xlate

sources:
  - files:
      - common/xlate_pkg.sv
      - verilog/dmw_match.sv
      - verilog/xlate_csr.sv
      - verilog/xlate_ctrl.sv
      - tlb/tlb_array.sv
      - verilog/xlate_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/xlate_tb.sv

/* common/xlate_pkg.sv */
`default_nettype none

package xlate_pkg;

    localparam int ADDR_W      = 32;
    localparam int CSR_NUM_W   = 14;
    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;
    localparam int VPPN_W      = 19;
    localparam int PPN_W       = 20;
    localparam int ASID_W      = 10;

    localparam logic [CSR_NUM_W-1:0] CSR_CRMD    = 14'h0;
    localparam logic [CSR_NUM_W-1:0] CSR_ASID    = 14'h18;
    localparam logic [CSR_NUM_W-1:0] CSR_TLBIDX  = 14'h10;
    localparam logic [CSR_NUM_W-1:0] CSR_TLBEHI  = 14'h11;
    localparam logic [CSR_NUM_W-1:0] CSR_TLBELO0 = 14'h12;
    localparam logic [CSR_NUM_W-1:0] CSR_TLBELO1 = 14'h13;
    localparam logic [CSR_NUM_W-1:0] CSR_DMW0    = 14'h180;
    localparam logic [CSR_NUM_W-1:0] CSR_DMW1    = 14'h181;

    // da set, pg clear, plv 0
    localparam logic [31:0] CRMD_RESET = 32'h0000_0008;

    typedef struct packed {
        logic [26:0] rsvd_hi;
        logic        pg;
        logic        da;
        logic        rsvd_lo;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [2:0]  vseg;
        logic        rsvd_a;
        logic [2:0]  pseg;
        logic [20:0] rsvd_b;
        logic        plv3;
        logic [1:0]  rsvd_c;
        logic        plv0;
    } dmw_t;

    typedef struct packed {
        logic [3:0]       rsvd_hi;
        logic [PPN_W-1:0] ppn;
        logic             rsvd_lo;
        logic             g;
        logic [1:0]       mat;
        logic [1:0]       plv;
        logic             d;
        logic             v;
    } tlbelo_t;

    // same write word, two views
    typedef union packed {
        tlbelo_t elo;
        dmw_t    dmw;
    } csr_word_u;

    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       plv;
        logic             d;
        logic             v;
    } tlb_half_t;

    typedef struct packed {
        logic                 found;
        logic [TLB_IDX_W-1:0] index;
        tlb_half_t            half;
    } tlb_hit_t;

    typedef struct packed {
        logic              e;
        logic [VPPN_W-1:0] vppn;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_half_t         half0;
        tlb_half_t         half1;
    } tlb_entry_t;

    typedef struct packed {
        logic [TLB_IDX_W-1:0] index;
        tlb_entry_t           entry;
    } tlb_wr_t;

    typedef struct packed {
        logic              hit;
        logic [ADDR_W-1:0] paddr;
    } dmw_hit_t;

    typedef enum logic [2:0] {
        FAULT_NONE = 3'd0,
        FAULT_TLBR = 3'd1,
        FAULT_PIF  = 3'd2,
        FAULT_PIL  = 3'd3,
        FAULT_PIS  = 3'd4,
        FAULT_PPI  = 3'd5,
        FAULT_PME  = 3'd6
    } xlate_fault_e;

    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        xlate_fault_e      fault;
    } xlate_rsp_t;

endpackage

`default_nettype wire

/* tb/xlate_ref.svh */
`ifndef XLATE_REF_SVH
`define XLATE_REF_SVH

// plv1 and plv2 have no window enable
function automatic logic window_hits(input logic [31:0] dmw, input logic [1:0] plv,
                                     input logic [31:0] va);
    logic lvl_ok;
    lvl_ok = (plv == 2'd0 && dmw[0]) || (plv == 2'd3 && dmw[3]);
    return lvl_ok && (dmw[31:29] == va[31:29]);
endfunction

// expected response from the shadow csrs and tlb entries
function automatic xlate_rsp_t xlate_ref(input logic [31:0] va, input logic is_fetch,
                                         input logic is_store);
    xlate_rsp_t  r;
    logic [1:0]  plv;
    logic [31:0] elo;
    int          hit;
    r.paddr = '0;
    r.fault = FAULT_NONE;
    plv = sh_crmd[1:0];
    hit = -1;
    // the lookup compares vppn with vaddr bits 31..13
    for (int i = 0; i < TLB_ENTRIES; i++) begin
        if (tlb_e[i] && tlb_vppn[i] == va[31:13] && (tlb_g[i] || tlb_asid[i] == sh_asid))
            hit = i;
    end
    if (sh_crmd[3]) begin
        r.paddr = va;
    end else if (window_hits(sh_dmw0, plv, va)) begin
        r.paddr = {sh_dmw0[27:25], va[28:0]};
    end else if (window_hits(sh_dmw1, plv, va)) begin
        r.paddr = {sh_dmw1[27:25], va[28:0]};
    end else if (hit < 0) begin
        r.fault = FAULT_TLBR;
    end else begin
        elo = va[12] ? tlb_lo1[hit] : tlb_lo0[hit];
        if (!elo[0]) begin
            if (is_fetch)
                r.fault = FAULT_PIF;
            else if (is_store)
                r.fault = FAULT_PIS;
            else
                r.fault = FAULT_PIL;
        end else if (plv > elo[3:2]) begin
            r.fault = FAULT_PPI;
        end else if (is_store && !elo[1]) begin
            r.fault = FAULT_PME;
        end else begin
            r.paddr = {elo[27:8], va[11:0]};
        end
    end
    return r;
endfunction

`endif

/* tb/xlate_tb.sv */
`default_nettype none

module xlate_tb import xlate_pkg::*; ();

    localparam int CLK_PERIOD      = 8;
    localparam int DIRECTED_CYCLES = 100;
    localparam int RANDOM_CYCLES   = 600;

    logic                 clk;
    logic                 reset;
    logic                 csr_we;
    logic [CSR_NUM_W-1:0] csr_num;
    logic [31:0]          csr_wvalue;
    logic [31:0]          csr_rvalue;
    logic                 tlbwr;
    logic                 fetch_req;
    logic [ADDR_W-1:0]    fetch_vaddr;
    logic                 data_req;
    logic [ADDR_W-1:0]    data_vaddr;
    logic                 data_store;
    logic                 fetch_rsp_valid;
    xlate_rsp_t           fetch_rsp;
    logic                 data_rsp_valid;
    xlate_rsp_t           data_rsp;

    // shadow state
    logic [31:0]       sh_crmd;
    logic [ASID_W-1:0] sh_asid;
    logic [31:0]       sh_dmw0;
    logic [31:0]       sh_dmw1;
    logic [31:0]       sh_tlbidx;
    logic [31:0]       sh_tlbehi;
    logic [31:0]       sh_elo0;
    logic [31:0]       sh_elo1;
    logic              tlb_e [TLB_ENTRIES];
    logic [VPPN_W-1:0] tlb_vppn [TLB_ENTRIES];
    logic [ASID_W-1:0] tlb_asid [TLB_ENTRIES];
    logic              tlb_g [TLB_ENTRIES];
    logic [31:0]       tlb_lo0 [TLB_ENTRIES];
    logic [31:0]       tlb_lo1 [TLB_ENTRIES];

    // next cycle's stimulus
    logic                 nx_we;
    logic [CSR_NUM_W-1:0] nx_num;
    logic [31:0]          nx_wv;
    logic                 nx_wr;
    logic                 nx_freq;
    logic [ADDR_W-1:0]    nx_fva;
    logic                 nx_dreq;
    logic [ADDR_W-1:0]    nx_dva;
    logic                 nx_st;

    logic       exp_freq;
    logic       exp_dreq;
    xlate_rsp_t exp_fetch;
    xlate_rsp_t exp_data;
    logic [31:0] exp_rd;
    logic       exp_rd_on;
    logic       due_freq;
    logic       due_dreq;
    xlate_rsp_t due_fetch;
    xlate_rsp_t due_data;

    logic [CSR_NUM_W-1:0] csr_list [8];
    integer seed;
    integer r;
    int     value_errs;
    int     pulse_errs;

    `include "xlate_ref.svh"

    xlate_top DUT (
        .clk             (clk),
        .reset           (reset),
        .csr_we          (csr_we),
        .csr_num         (csr_num),
        .csr_wvalue      (csr_wvalue),
        .csr_rvalue      (csr_rvalue),
        .tlbwr           (tlbwr),
        .fetch_req       (fetch_req),
        .fetch_vaddr     (fetch_vaddr),
        .data_req        (data_req),
        .data_vaddr      (data_vaddr),
        .data_store      (data_store),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp        (data_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] read_shadow(input logic [CSR_NUM_W-1:0] num);
        case (num)
            CSR_CRMD:    return sh_crmd;
            CSR_ASID:    return {22'h0, sh_asid};
            CSR_TLBIDX:  return sh_tlbidx;
            CSR_TLBEHI:  return sh_tlbehi;
            CSR_TLBELO0: return sh_elo0;
            CSR_TLBELO1: return sh_elo1;
            CSR_DMW0:    return sh_dmw0;
            CSR_DMW1:    return sh_dmw1;
            default:     return 32'h0;
        endcase
    endfunction

    // writable fields only
    task automatic update_csrs(input logic [CSR_NUM_W-1:0] num, input logic [31:0] v);
        case (num)
            CSR_CRMD:    sh_crmd = v & 32'h0000_001b;
            CSR_ASID:    sh_asid = v[ASID_W-1:0];
            CSR_TLBIDX:  sh_tlbidx = v & 32'h8000_000f;
            CSR_TLBEHI:  sh_tlbehi = v & 32'hffff_e000;
            CSR_TLBELO0: sh_elo0 = v & 32'h0fff_ff7f;
            CSR_TLBELO1: sh_elo1 = v & 32'h0fff_ff7f;
            CSR_DMW0:    sh_dmw0 = v & 32'hee00_0009;
            CSR_DMW1:    sh_dmw1 = v & 32'hee00_0009;
            default: ;
        endcase
    endtask

    task automatic store_entry();
        int idx;
        idx = sh_tlbidx[3:0];
        tlb_e[idx]    = ~sh_tlbidx[31];
        tlb_vppn[idx] = sh_tlbehi[31:13];
        tlb_asid[idx] = sh_asid;
        tlb_g[idx]    = sh_elo0[6] & sh_elo1[6];
        tlb_lo0[idx]  = sh_elo0;
        tlb_lo1[idx]  = sh_elo1;
    endtask

    // one clock of stimulus; expectations use the state before this cycle's writes
    task automatic step();
        @(posedge clk);
        csr_we      <= nx_we;
        csr_num     <= nx_num;
        csr_wvalue  <= nx_wv;
        tlbwr       <= nx_wr;
        fetch_req   <= nx_freq;
        fetch_vaddr <= nx_fva;
        data_req    <= nx_dreq;
        data_vaddr  <= nx_dva;
        data_store  <= nx_st;
        exp_freq  = nx_freq;
        exp_fetch = xlate_ref(nx_fva, 1'b1, 1'b0);
        exp_dreq  = nx_dreq;
        exp_data  = xlate_ref(nx_dva, 1'b0, nx_st);
        exp_rd    = read_shadow(nx_num);
        exp_rd_on = 1'b1;
        if (nx_wr)
            store_entry();
        if (nx_we)
            update_csrs(nx_num, nx_wv);
        nx_we   = 1'b0;
        nx_wr   = 1'b0;
        nx_freq = 1'b0;
        nx_dreq = 1'b0;
        nx_st   = 1'b0;
    endtask

    task automatic write_csr(input logic [CSR_NUM_W-1:0] num, input logic [31:0] value);
        nx_we  = 1'b1;
        nx_num = num;
        nx_wv  = value;
        step();
    endtask

    task automatic read_csr(input logic [CSR_NUM_W-1:0] num);
        nx_num = num;
        step();
    endtask

    task automatic request(input logic [31:0] fva, input logic [31:0] dva, input logic store);
        nx_freq = 1'b1;
        nx_fva  = fva;
        nx_dreq = 1'b1;
        nx_dva  = dva;
        nx_st   = store;
        step();
    endtask

    task automatic fill_tlb(input logic [3:0] idx, input logic [18:0] vppn,
                            input logic [31:0] lo0, input logic [31:0] lo1);
        write_csr(CSR_TLBIDX, {28'h0, idx});
        write_csr(CSR_TLBEHI, {vppn, 13'h0});
        write_csr(CSR_TLBELO0, lo0);
        write_csr(CSR_TLBELO1, lo1);
        nx_wr = 1'b1;
        step();
    endtask

    function automatic logic [31:0] make_elo(input logic [19:0] ppn, input logic [1:0] plv,
                                             input logic g, input logic d, input logic v);
        return {4'h0, ppn, 1'b0, g, 2'b00, plv, d, v};
    endfunction

    // vppn in bits 31..13 and bit 12 picks the odd half
    function automatic logic [31:0] page_va(input logic [18:0] vppn, input logic odd,
                                            input logic [11:0] off);
        return {vppn, odd, off};
    endfunction

    function automatic logic [31:0] random_value(input logic [CSR_NUM_W-1:0] num);
        logic [31:0] v;
        v = $random(seed);
        case (num)
            CSR_CRMD:   v = (v & 32'h13) | ((v[10:8] == 3'd0) ? 32'h8 : 32'h0);
            CSR_ASID:   v = v & 32'h3;
            CSR_TLBEHI: v = (v & 32'h3f) << 13;
            CSR_TLBIDX: v = (v & 32'hf) | ((v[9:8] == 2'd0) ? 32'h8000_0000 : 32'h0);
            default: ;
        endcase
        return v;
    endfunction

    function automatic logic [31:0] random_va();
        logic [31:0] va;
        logic [31:0] sel;
        va  = $random(seed);
        sel = $random(seed);
        if (sel[1:0] != 2'd0)
            va[31:13] = {13'h0, sel[13:8]};
        return va;
    endfunction

    // keeps vppn values unique among valid entries
    function automatic logic write_is_unique();
        if (sh_tlbidx[31])
            return 1'b1;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (i != sh_tlbidx[3:0] && tlb_e[i] && tlb_vppn[i] == sh_tlbehi[31:13])
                return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic compare_rsp(input string name, input logic valid, input xlate_rsp_t got,
                               input logic want_valid, input xlate_rsp_t want);
        if (valid !== want_valid) begin
            if (want_valid)
                $display("%s response pulse missing at time %0t", name, $time);
            else
                $display("%s response pulse without a request at time %0t", name, $time);
            pulse_errs++;
        end else if (valid) begin
            if (got.paddr !== want.paddr) begin
                $display("ERR %s_rsp.paddr got %h exp %h", name, got.paddr, want.paddr);
                value_errs++;
            end
            if (got.fault !== want.fault) begin
                $display("ERR %s_rsp.fault got %h exp %h", name, got.fault, want.fault);
                value_errs++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            compare_rsp("fetch", fetch_rsp_valid, fetch_rsp, due_freq, due_fetch);
            compare_rsp("data", data_rsp_valid, data_rsp, due_dreq, due_data);
            if (exp_rd_on && csr_rvalue !== exp_rd) begin
                $display("ERR csr_rvalue got %h exp %h", csr_rvalue, exp_rd);
                value_errs++;
            end
        end
        due_freq  = exp_freq;
        due_fetch = exp_fetch;
        due_dreq  = exp_dreq;
        due_data  = exp_data;
    end

    initial begin
        #(CLK_PERIOD * (DIRECTED_CYCLES + RANDOM_CYCLES + 100));
        $display("watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        seed = 48;
        csr_list = '{CSR_CRMD, CSR_ASID, CSR_TLBIDX, CSR_TLBEHI,
                     CSR_TLBELO0, CSR_TLBELO1, CSR_DMW0, CSR_DMW1};
        reset       <= 1'b1;
        csr_we      <= 1'b0;
        csr_num     <= '0;
        csr_wvalue  <= '0;
        tlbwr       <= 1'b0;
        fetch_req   <= 1'b0;
        fetch_vaddr <= '0;
        data_req    <= 1'b0;
        data_vaddr  <= '0;
        data_store  <= 1'b0;
        {nx_we, nx_num, nx_wv, nx_wr, nx_freq, nx_fva, nx_dreq, nx_dva, nx_st} = '0;
        {exp_freq, exp_dreq, exp_rd_on, due_freq, due_dreq} = '0;
        sh_crmd = 32'h8;
        {sh_asid, sh_dmw0, sh_dmw1, sh_tlbidx, sh_tlbehi, sh_elo0, sh_elo1} = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            tlb_e[i] = 1'b0;
        end
        value_errs = 0;
        pulse_errs = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // direct mode out of reset
        read_csr(CSR_CRMD);
        request(32'h1234_5678, 32'hdead_beef, 1'b0);
        request(32'hfedc_ba98, 32'h0000_1000, 1'b1);

        // windows at plv0 and plv3
        write_csr(CSR_CRMD, 32'h10);
        write_csr(CSR_DMW0, 32'ha200_0001);
        write_csr(CSR_DMW1, 32'h8000_0008);
        request(32'ha000_1234, 32'h8000_5678, 1'b0);
        write_csr(CSR_CRMD, 32'h13);
        request(32'ha000_1234, 32'h8000_5678, 1'b0);
        write_csr(CSR_CRMD, 32'h10);

        // tlb hits, asid and global
        request(page_va(19'h24, 1'b0, 12'h345), page_va(19'h31, 1'b1, 12'habc), 1'b0);
        read_csr(CSR_DMW0);
        write_csr(CSR_ASID, 32'h5);
        fill_tlb(4'd0, 19'h24, make_elo(20'h11111, 2'd0, 1'b0, 1'b1, 1'b1),
                 make_elo(20'h22222, 2'd0, 1'b0, 1'b1, 1'b1));
        fill_tlb(4'd1, 19'h31, make_elo(20'h33333, 2'd0, 1'b1, 1'b1, 1'b1),
                 make_elo(20'h44444, 2'd0, 1'b1, 1'b1, 1'b1));
        request(page_va(19'h24, 1'b0, 12'h345), page_va(19'h31, 1'b1, 12'habc), 1'b0);
        request(page_va(19'h24, 1'b1, 12'h678), page_va(19'h31, 1'b0, 12'h123), 1'b0);
        write_csr(CSR_ASID, 32'h7);
        request(page_va(19'h24, 1'b0, 12'h345), page_va(19'h31, 1'b1, 12'h010), 1'b1);

        // invalid, privileged and clean pages
        fill_tlb(4'd2, 19'h40, make_elo(20'h55555, 2'd0, 1'b0, 1'b1, 1'b0),
                 make_elo(20'h66666, 2'd0, 1'b0, 1'b1, 1'b0));
        request(page_va(19'h40, 1'b0, 12'h100), page_va(19'h40, 1'b1, 12'h200), 1'b0);
        request(page_va(19'h40, 1'b1, 12'h100), page_va(19'h40, 1'b0, 12'h200), 1'b1);
        fill_tlb(4'd3, 19'h42, make_elo(20'h77777, 2'd0, 1'b0, 1'b1, 1'b1),
                 make_elo(20'h77777, 2'd0, 1'b0, 1'b1, 1'b1));
        fill_tlb(4'd4, 19'h44, make_elo(20'h88888, 2'd3, 1'b0, 1'b0, 1'b1),
                 make_elo(20'h99999, 2'd3, 1'b0, 1'b0, 1'b1));
        request(page_va(19'h42, 1'b0, 12'h004), page_va(19'h44, 1'b1, 12'h008), 1'b1);
        request(page_va(19'h44, 1'b0, 12'h00c), page_va(19'h44, 1'b1, 12'h010), 1'b0);
        write_csr(CSR_CRMD, 32'h13);
        request(page_va(19'h42, 1'b1, 12'h014), page_va(19'h42, 1'b0, 12'h018), 1'b0);
        request(page_va(19'h44, 1'b0, 12'h01c), page_va(19'h44, 1'b1, 12'h020), 1'b1);

        // random mix
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r = $random(seed);
            nx_num = csr_list[r[2:0]];
            nx_we  = (r[4:3] == 2'd0);
            if (nx_we)
                nx_wv = random_value(nx_num);
            nx_wr   = (r[7:6] == 2'd0) && write_is_unique();
            nx_freq = r[8];
            nx_dreq = r[9];
            nx_st   = r[10];
            nx_fva  = random_va();
            nx_dva  = random_va();
            step();
        end

        repeat (3) step();
        @(posedge clk);
        $display("value errors %0d, pulse errors %0d", value_errs, pulse_errs);
        if (value_errs == 0 && pulse_errs == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* tlb/tlb_array.sv */
`default_nettype none

module tlb_array import xlate_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tlbwr,
    input  logic [TLB_IDX_W-1:0] tlb_windex,
    input  tlb_entry_t           tlb_wentry,
    input  logic [ASID_W-1:0]    asid,
    input  logic [ADDR_W-1:0]    s0_vaddr,
    input  logic [ADDR_W-1:0]    s1_vaddr,
    output tlb_hit_t             s0_hit,
    output tlb_hit_t             s1_hit
);

    // entry valid bits
    logic [TLB_ENTRIES-1:0] tlb_e;
    tlb_entry_t             tlb_mem [TLB_ENTRIES];

    logic [TLB_ENTRIES-1:0] s0_match;
    logic [TLB_ENTRIES-1:0] s1_match;

    function automatic logic entry_hit(input tlb_entry_t ent, input logic [VPPN_W-1:0] vppn,
                                       input logic [ASID_W-1:0] cur_asid);
        return (ent.vppn == vppn) && (ent.g || ent.asid == cur_asid);
    endfunction

    // one-hot match, so the loop acts as a mux
    function automatic tlb_hit_t pick(input logic [TLB_ENTRIES-1:0] match, input logic odd,
                                      input tlb_entry_t mem [TLB_ENTRIES]);
        tlb_hit_t h;
        h = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) begin
                h.found = 1'b1;
                h.index = TLB_IDX_W'(i);
                h.half  = odd ? mem[i].half1 : mem[i].half0;
            end
        end
        return h;
    endfunction

    always_ff @(posedge clk) begin
        if (reset)
            tlb_e <= '0;
        else if (tlbwr)
            tlb_e[tlb_windex] <= tlb_wentry.e;
    end

    always_ff @(posedge clk) begin
        if (tlbwr)
            tlb_mem[tlb_windex] <= tlb_wentry;
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            s0_match[i] = tlb_e[i] && entry_hit(tlb_mem[i], s0_vaddr[ADDR_W-1:13], asid);
            s1_match[i] = tlb_e[i] && entry_hit(tlb_mem[i], s1_vaddr[ADDR_W-1:13], asid);
        end
    end

    // bit 12 picks the odd page
    assign s0_hit = pick(s0_match, s0_vaddr[12], tlb_mem);
    assign s1_hit = pick(s1_match, s1_vaddr[12], tlb_mem);

    // duplicate entries written through the csr path would show up here
    a_s0_unique: assert property (@(posedge clk) disable iff (reset) $onehot0(s0_match));
    a_s1_unique: assert property (@(posedge clk) disable iff (reset) $onehot0(s1_match));

endmodule

`default_nettype wire

/* verilog/dmw_match.sv */
`default_nettype none

module dmw_match import xlate_pkg::*; (
    input  logic [ADDR_W-1:0] vaddr,
    input  logic [1:0]        plv,
    input  dmw_t              dmw0,
    input  dmw_t              dmw1,
    output dmw_hit_t          hit
);

    logic hit0;
    logic hit1;

    // only plv0 and plv3 have enable bits
    function automatic logic win_hit(input dmw_t win, input logic [1:0] lvl,
                                     input logic [2:0] seg);
        logic lvl_ok;
        lvl_ok = (lvl == 2'd0 && win.plv0) || (lvl == 2'd3 && win.plv3);
        return lvl_ok && (win.vseg == seg);
    endfunction

    assign hit0 = win_hit(dmw0, plv, vaddr[ADDR_W-1:ADDR_W-3]);
    assign hit1 = win_hit(dmw1, plv, vaddr[ADDR_W-1:ADDR_W-3]);

    // dmw0 wins when both match
    always_comb begin
        hit.hit   = hit0 | hit1;
        hit.paddr = {hit0 ? dmw0.pseg : dmw1.pseg, vaddr[ADDR_W-4:0]};
    end

endmodule

`default_nettype wire

/* verilog/xlate_csr.sv */
`default_nettype none

module xlate_csr import xlate_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 csr_we,
    input  logic [CSR_NUM_W-1:0] csr_num,
    input  logic [31:0]          csr_wvalue,
    output logic [31:0]          csr_rvalue,
    output crmd_t                crmd,
    output logic [ASID_W-1:0]    asid,
    output dmw_t                 dmw0,
    output dmw_t                 dmw1,
    output tlb_wr_t              tlb_wentry
);

    logic                 tlbidx_ne;
    logic [TLB_IDX_W-1:0] tlbidx_index;
    logic [VPPN_W-1:0]    tlbehi_vppn;
    tlbelo_t              tlbelo0;
    tlbelo_t              tlbelo1;

    csr_word_u            wv;
    crmd_t                crmd_w;
    tlbelo_t              elo_w;
    dmw_t                 dmw_w;

    function automatic tlb_half_t elo_half(input tlbelo_t elo);
        return '{ppn: elo.ppn, plv: elo.plv, d: elo.d, v: elo.v};
    endfunction

    // reserved bits read as zero
    always_comb begin
        wv             = csr_wvalue;
        crmd_w         = crmd_t'(csr_wvalue);
        crmd_w.rsvd_hi = '0;
        crmd_w.rsvd_lo = 1'b0;
        elo_w          = wv.elo;
        elo_w.rsvd_hi  = '0;
        elo_w.rsvd_lo  = 1'b0;
        dmw_w          = wv.dmw;
        dmw_w.rsvd_a   = 1'b0;
        dmw_w.rsvd_b   = '0;
        dmw_w.rsvd_c   = '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd         <= crmd_t'(CRMD_RESET);
            asid         <= '0;
            dmw0         <= '0;
            dmw1         <= '0;
            tlbidx_ne    <= 1'b0;
            tlbidx_index <= '0;
            tlbehi_vppn  <= '0;
            tlbelo0      <= '0;
            tlbelo1      <= '0;
        end else if (csr_we) begin
            case (csr_num)
                CSR_CRMD:    crmd <= crmd_w;
                CSR_ASID:    asid <= csr_wvalue[ASID_W-1:0];
                CSR_TLBIDX: begin
                    tlbidx_ne    <= csr_wvalue[31];
                    tlbidx_index <= csr_wvalue[TLB_IDX_W-1:0];
                end
                CSR_TLBEHI:  tlbehi_vppn <= csr_wvalue[31:13];
                CSR_TLBELO0: tlbelo0 <= elo_w;
                CSR_TLBELO1: tlbelo1 <= elo_w;
                CSR_DMW0:    dmw0 <= dmw_w;
                CSR_DMW1:    dmw1 <= dmw_w;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (csr_num)
            CSR_CRMD:    csr_rvalue = crmd;
            CSR_ASID:    csr_rvalue = {{(32-ASID_W){1'b0}}, asid};
            CSR_TLBIDX:  csr_rvalue = {tlbidx_ne, {(31-TLB_IDX_W){1'b0}}, tlbidx_index};
            CSR_TLBEHI:  csr_rvalue = {tlbehi_vppn, {(32-VPPN_W){1'b0}}};
            CSR_TLBELO0: csr_rvalue = tlbelo0;
            CSR_TLBELO1: csr_rvalue = tlbelo1;
            CSR_DMW0:    csr_rvalue = dmw0;
            CSR_DMW1:    csr_rvalue = dmw1;
            default:     csr_rvalue = '0;
        endcase
    end

    // entry that the next tlbwr stores
    always_comb begin
        tlb_wentry.index       = tlbidx_index;
        tlb_wentry.entry.e     = ~tlbidx_ne;
        tlb_wentry.entry.vppn  = tlbehi_vppn;
        tlb_wentry.entry.asid  = asid;
        tlb_wentry.entry.g     = tlbelo0.g & tlbelo1.g;
        tlb_wentry.entry.half0 = elo_half(tlbelo0);
        tlb_wentry.entry.half1 = elo_half(tlbelo1);
    end

endmodule

`default_nettype wire

/* verilog/xlate_ctrl.sv */
`default_nettype none

module xlate_ctrl import xlate_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  crmd_t             crmd,

    input  logic              fetch_req,
    input  logic [ADDR_W-1:0] fetch_vaddr,
    input  logic              data_req,
    input  logic [ADDR_W-1:0] data_vaddr,
    input  logic              data_store,

    input  dmw_hit_t          fetch_dmw,
    input  dmw_hit_t          data_dmw,
    input  tlb_hit_t          fetch_tlb,
    input  tlb_hit_t          data_tlb,

    output logic              fetch_rsp_valid,
    output xlate_rsp_t        fetch_rsp,
    output logic              data_rsp_valid,
    output xlate_rsp_t        data_rsp
);

    xlate_rsp_t fetch_next;
    xlate_rsp_t data_next;

    // mode select, then faults in priority order
    function automatic xlate_rsp_t translate(
        input logic [ADDR_W-1:0] va,
        input logic              is_fetch,
        input logic              is_store,
        input crmd_t             cr,
        input dmw_hit_t          dh,
        input tlb_hit_t          th
    );
        xlate_rsp_t r;
        r.paddr = '0;
        r.fault = FAULT_NONE;
        if (cr.da) begin
            r.paddr = va;
        end else if (dh.hit) begin
            r.paddr = dh.paddr;
        end else if (!th.found) begin
            r.fault = FAULT_TLBR;
        end else if (!th.half.v) begin
            if (is_fetch)
                r.fault = FAULT_PIF;
            else if (is_store)
                r.fault = FAULT_PIS;
            else
                r.fault = FAULT_PIL;
        end else if (cr.plv > th.half.plv) begin
            r.fault = FAULT_PPI;
        end else if (is_store && !th.half.d) begin
            r.fault = FAULT_PME;
        end else begin
            r.paddr = {th.half.ppn, va[11:0]};
        end
        return r;
    endfunction

    assign fetch_next = translate(fetch_vaddr, 1'b1, 1'b0, crmd, fetch_dmw, fetch_tlb);
    assign data_next  = translate(data_vaddr, 1'b0, data_store, crmd, data_dmw, data_tlb);

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_rsp_valid <= 1'b0;
            data_rsp_valid  <= 1'b0;
        end else begin
            fetch_rsp_valid <= fetch_req;
            data_rsp_valid  <= data_req;
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        fetch_rsp <= fetch_next;
        data_rsp  <= data_next;
    end

    a_fetch_pulse: assert property (@(posedge clk) disable iff (reset)
        fetch_req |=> fetch_rsp_valid);
    a_fetch_cause: assert property (@(posedge clk) disable iff (reset)
        fetch_rsp_valid |-> $past(fetch_req));
    a_data_pulse: assert property (@(posedge clk) disable iff (reset)
        data_req |=> data_rsp_valid);
    a_data_cause: assert property (@(posedge clk) disable iff (reset)
        data_rsp_valid |-> $past(data_req));

    // faulting responses carry no address
    a_fetch_zero: assert property (@(posedge clk) disable iff (reset)
        fetch_rsp_valid && fetch_rsp.fault != FAULT_NONE |-> fetch_rsp.paddr == '0);
    a_data_zero: assert property (@(posedge clk) disable iff (reset)
        data_rsp_valid && data_rsp.fault != FAULT_NONE |-> data_rsp.paddr == '0);

endmodule

`default_nettype wire

/* verilog/xlate_top.sv */
`default_nettype none

module xlate_top import xlate_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 csr_we,
    input  logic [CSR_NUM_W-1:0] csr_num,
    input  logic [31:0]          csr_wvalue,
    output logic [31:0]          csr_rvalue,

    input  logic                 tlbwr,

    input  logic                 fetch_req,
    input  logic [ADDR_W-1:0]    fetch_vaddr,
    input  logic                 data_req,
    input  logic [ADDR_W-1:0]    data_vaddr,
    input  logic                 data_store,

    output logic                 fetch_rsp_valid,
    output xlate_rsp_t           fetch_rsp,
    output logic                 data_rsp_valid,
    output xlate_rsp_t           data_rsp
);

    crmd_t             crmd;
    logic [ASID_W-1:0] asid;
    dmw_t              dmw0;
    dmw_t              dmw1;
    tlb_wr_t           tlb_wentry;

    tlb_hit_t          fetch_tlb;
    tlb_hit_t          data_tlb;
    dmw_hit_t          fetch_dmw;
    dmw_hit_t          data_dmw;

    xlate_csr u_csr (
        .clk        (clk),
        .reset      (reset),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wvalue (csr_wvalue),
        .csr_rvalue (csr_rvalue),
        .crmd       (crmd),
        .asid       (asid),
        .dmw0       (dmw0),
        .dmw1       (dmw1),
        .tlb_wentry (tlb_wentry)
    );

    // port 0 fetch, port 1 data
    tlb_array u_tlb (
        .clk        (clk),
        .reset      (reset),
        .tlbwr      (tlbwr),
        .tlb_windex (tlb_wentry.index),
        .tlb_wentry (tlb_wentry.entry),
        .asid       (asid),
        .s0_vaddr   (fetch_vaddr),
        .s1_vaddr   (data_vaddr),
        .s0_hit     (fetch_tlb),
        .s1_hit     (data_tlb)
    );

    dmw_match u_fetch_dmw (
        .vaddr (fetch_vaddr),
        .plv   (crmd.plv),
        .dmw0  (dmw0),
        .dmw1  (dmw1),
        .hit   (fetch_dmw)
    );

    dmw_match u_data_dmw (
        .vaddr (data_vaddr),
        .plv   (crmd.plv),
        .dmw0  (dmw0),
        .dmw1  (dmw1),
        .hit   (data_dmw)
    );

    xlate_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .crmd            (crmd),
        .fetch_req       (fetch_req),
        .fetch_vaddr     (fetch_vaddr),
        .data_req        (data_req),
        .data_vaddr      (data_vaddr),
        .data_store      (data_store),
        .fetch_dmw       (fetch_dmw),
        .data_dmw        (data_dmw),
        .fetch_tlb       (fetch_tlb),
        .data_tlb        (data_tlb),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp        (data_rsp)
    );

endmodule

`default_nettype wire

/* xlate.f */
+incdir+tb
common/xlate_pkg.sv
verilog/dmw_match.sv
verilog/xlate_csr.sv
verilog/xlate_ctrl.sv
tlb/tlb_array.sv
verilog/xlate_top.sv
tb/xlate_tb.sv
